// File: design/dedisp_stream_pkg.sv
`default_nettype none

// sample stream types shared by the datapath and the testbench
package dedisp_stream_pkg;

    // width of one component of a complex bin
    localparam int COMP_W = 16;

    // one complex fft bin
    // re sits in the upper half, im in the lower half
    typedef struct packed {
        logic signed [COMP_W-1:0] re;
        logic signed [COMP_W-1:0] im;
    } sample_t;

endpackage

`default_nettype wire

// File: design/dedisp_regs_pkg.sv
`default_nettype none

// apb bus structs and the register map of the dedispersion stage
package dedisp_regs_pkg;

    // bus widths
    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;

    // width of one per-channel delay value, in spectra
    localparam int DELAY_W = 8;

    // request side, driven by the master
    typedef struct packed {
        logic [APB_ADDR_W-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    // response side, driven by the slave
    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // control register
    localparam logic [APB_ADDR_W-1:0] CTRL_OFFSET = 12'h000;
    localparam int CTRL_ENABLE_BIT = 0;

    // delay registers, one word per channel
    localparam logic [APB_ADDR_W-1:0] DELAY_BASE = 12'h010;
    localparam int DELAY_STRIDE = 4;

    // delay value after reset
    localparam int DELAY_RESET = 1;

endpackage

`default_nettype wire

// File: design/dedisp_delay_line.sv
`timescale 1ns/10ps
`default_nettype none

module dedisp_delay_line #(
    parameter type payload_t = logic [31:0],
    parameter int  MAX_DELAY = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [dedisp_regs_pkg::DELAY_W-1:0] delay,
    input  logic                                load,
    input  logic                                strobe,
    input  payload_t                            din,
    output payload_t                            dout,
    output logic                                dout_valid
);
    import dedisp_regs_pkg::*;

    // one spare entry so a delay of MAX_DELAY never reads the slot being written
    localparam int DEPTH = MAX_DELAY + 1;
    localparam int PTR_W = $clog2(DEPTH);

    payload_t           ring [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   wr_ptr_next;
    logic [PTR_W-1:0]   rd_addr;
    logic [PTR_W-1:0]   rd_addr_q;
    int                 rd_calc;
    logic [DELAY_W-1:0] fill;
    logic               full;
    logic               rd_pend;

    // ring pointer wraps at DEPTH, not a power of two
    assign wr_ptr_next = (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

    // slot written delay strobes ago
    always_comb begin
        rd_calc = int'(wr_ptr) - int'(delay);
        if (rd_calc < 0) begin
            rd_calc = rd_calc + DEPTH;
        end
        rd_addr = PTR_W'(rd_calc);
    end

    // enough history for this strobe to release an output
    assign full = (fill >= delay);

    // pointer, fill count and read pipeline control
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            fill       <= '0;
            rd_pend    <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            // a load drops the history, so a coinciding strobe releases nothing
            rd_pend    <= strobe && full && !load;
            dout_valid <= rd_pend;
            if (strobe) begin
                wr_ptr <= wr_ptr_next;
            end
            if (load) begin
                fill <= '0;
            end else if (strobe && !full) begin
                fill <= fill + 1'b1;
            end
        end
    end

    // storage with a registered read one cycle after the strobe
    always_ff @(posedge clk) begin
        if (strobe) begin
            ring[wr_ptr] <= din;
            rd_addr_q    <= rd_addr;
        end
        // old contents on a same-edge write, which is what a full-depth delay needs
        if (rd_pend) begin
            dout <= ring[rd_addr_q];
        end
    end

    // fill stays within the delay since a new delay always comes with a load
    a_fill_within_delay: assert property (
        @(posedge clk) disable iff (rst)
        !load |-> (fill <= delay)
    );

    // register block keeps the delay inside the ring
    a_delay_in_range: assert property (
        @(posedge clk) disable iff (rst)
        strobe |-> (delay != '0) && (int'(delay) <= MAX_DELAY)
    );

endmodule

`default_nettype wire

// File: design/dedispersor.sv
`timescale 1ns/10ps
`default_nettype none

module dedispersor #(
    parameter int N_CHANNELS = 8,
    parameter int MAX_DELAY  = 16
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           enable,
    input  logic [N_CHANNELS*dedisp_regs_pkg::DELAY_W-1:0] delays,
    input  logic [N_CHANNELS-1:0]                          delay_load,
    input  dedisp_stream_pkg::sample_t                     sample_in,
    input  logic                                           in_valid,
    output dedisp_stream_pkg::sample_t                     sample_out,
    output logic [$clog2(N_CHANNELS)-1:0]                  out_chan,
    output logic                                           out_valid
);
    import dedisp_stream_pkg::*;
    import dedisp_regs_pkg::*;

    localparam int CH_W = $clog2(N_CHANNELS);

    logic [CH_W-1:0]       chan_cnt;
    logic                  accept;
    logic [N_CHANNELS-1:0] strobe;
    sample_t               line_out [N_CHANNELS];
    logic [N_CHANNELS-1:0] line_valid;
    sample_t               sel_sample;
    logic [CH_W-1:0]       sel_chan;

    // samples are dropped while disabled
    assign accept = in_valid && enable;

    // channel position in the spectrum
    // wraps by itself since N_CHANNELS is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            chan_cnt <= '0;
        end else if (accept) begin
            chan_cnt <= chan_cnt + 1'b1;
        end
    end

    // steer the accepted sample to its channel
    always_comb begin
        strobe = '0;
        strobe[chan_cnt] = accept;
    end

    // one delay line per channel, all fed the same sample
    for (genvar c = 0; c < N_CHANNELS; c++) begin : g_line
        dedisp_delay_line #(
            .payload_t (sample_t),
            .MAX_DELAY (MAX_DELAY)
        ) u_line (
            .clk        (clk),
            .rst        (rst),
            .delay      (delays[c*DELAY_W +: DELAY_W]),
            .load       (delay_load[c]),
            .strobe     (strobe[c]),
            .din        (sample_in),
            .dout       (line_out[c]),
            .dout_valid (line_valid[c])
        );
    end

    // pick the line that fired
    // at most one fires per cycle, see assertion below
    always_comb begin
        sel_sample = line_out[0];
        sel_chan   = '0;
        for (int c = 0; c < N_CHANNELS; c++) begin
            if (line_valid[c]) begin
                sel_sample = line_out[c];
                sel_chan   = CH_W'(c);
            end
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= |line_valid;
        end
    end

    // data and channel tag only move with a valid output
    always_ff @(posedge clk) begin
        if (|line_valid) begin
            sample_out <= sel_sample;
            out_chan   <= sel_chan;
        end
    end

    // one strobe per cycle and equal latency in every line
    a_one_line_valid: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(line_valid)
    );

endmodule

`default_nettype wire

// File: design/dedisp_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module dedisp_apb_regs #(
    parameter int N_CHANNELS = 8,
    parameter int MAX_DELAY  = 16
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  dedisp_regs_pkg::apb_req_t                      apb_req,
    output dedisp_regs_pkg::apb_rsp_t                      apb_rsp,
    output logic                                           enable,
    output logic [N_CHANNELS*dedisp_regs_pkg::DELAY_W-1:0] delays,
    output logic [N_CHANNELS-1:0]                          delay_load
);
    import dedisp_regs_pkg::*;

    localparam int CH_W = $clog2(N_CHANNELS);

    logic [DELAY_W-1:0]    delay_q [N_CHANNELS];
    logic                  access;
    logic                  wr_access;
    logic                  rd_access;
    logic                  is_ctrl;
    logic                  is_delay;
    logic [APB_ADDR_W-1:0] delay_off;
    logic [CH_W-1:0]       chan_idx;
    logic                  bad_value;
    logic [APB_DATA_W-1:0] rd_data;

    // access phase of a transfer
    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;
    assign rd_access = access && !apb_req.pwrite;

    // address decode
    assign is_ctrl   = (apb_req.paddr == CTRL_OFFSET);
    assign delay_off = apb_req.paddr - DELAY_BASE;
    // word-aligned and inside the channel window
    assign is_delay  = (apb_req.paddr >= DELAY_BASE)
                    && (int'(delay_off) < N_CHANNELS * DELAY_STRIDE)
                    && (int'(delay_off) % DELAY_STRIDE == 0);
    assign chan_idx  = CH_W'(int'(delay_off) / DELAY_STRIDE);

    // zero delay has no meaning
    // above MAX_DELAY would overrun the ring
    assign bad_value = (apb_req.pwdata == '0)
                    || (apb_req.pwdata > APB_DATA_W'(MAX_DELAY));

    // read mux, zero-extended fields
    always_comb begin
        rd_data = '0;
        if (is_ctrl) begin
            rd_data[CTRL_ENABLE_BIT] = enable;
        end else if (is_delay) begin
            rd_data = APB_DATA_W'(delay_q[chan_idx]);
        end
    end

    // response is combinational, no wait states
    always_comb begin
        apb_rsp.prdata  = rd_access ? rd_data : '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access
                       && (!(is_ctrl || is_delay) || (apb_req.pwrite && is_delay && bad_value));
    end

    // register updates land at the end of the access cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            enable     <= 1'b0;
            delay_load <= '0;
            for (int c = 0; c < N_CHANNELS; c++) begin
                delay_q[c] <= DELAY_W'(DELAY_RESET);
            end
        end else begin
            delay_load <= '0;
            if (wr_access && is_ctrl) begin
                enable <= apb_req.pwdata[CTRL_ENABLE_BIT];
            end
            // rejected writes leave value and fill untouched
            if (wr_access && is_delay && !bad_value) begin
                delay_q[chan_idx]    <= DELAY_W'(apb_req.pwdata);
                delay_load[chan_idx] <= 1'b1;
            end
        end
    end

    // flatten for the datapath, channel 0 in the low bits
    for (genvar c = 0; c < N_CHANNELS; c++) begin : g_flat
        assign delays[c*DELAY_W +: DELAY_W] = delay_q[c];
    end

    // access phase only inside a selected transfer
    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel
    );

endmodule

`default_nettype wire

// File: design/dedisp_top.sv
`timescale 1ns/10ps
`default_nettype none

module dedisp_top #(
    parameter int N_CHANNELS = 8,
    parameter int MAX_DELAY  = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  dedisp_regs_pkg::apb_req_t     apb_req,
    output dedisp_regs_pkg::apb_rsp_t     apb_rsp,
    input  dedisp_stream_pkg::sample_t    sample_in,
    input  logic                          in_valid,
    output dedisp_stream_pkg::sample_t    sample_out,
    output logic [$clog2(N_CHANNELS)-1:0] out_chan,
    output logic                          out_valid
);
    import dedisp_regs_pkg::*;

    // config from the register block into the datapath
    logic                          enable;
    logic [N_CHANNELS*DELAY_W-1:0] delays;
    logic [N_CHANNELS-1:0]         delay_load;

    dedisp_apb_regs #(
        .N_CHANNELS (N_CHANNELS),
        .MAX_DELAY  (MAX_DELAY)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .enable     (enable),
        .delays     (delays),
        .delay_load (delay_load)
    );

    dedispersor #(
        .N_CHANNELS (N_CHANNELS),
        .MAX_DELAY  (MAX_DELAY)
    ) u_dedisp (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .delays     (delays),
        .delay_load (delay_load),
        .sample_in  (sample_in),
        .in_valid   (in_valid),
        .sample_out (sample_out),
        .out_chan   (out_chan),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

// File: test/dedisp_checker.sv
`timescale 1ns/10ps
`default_nettype none

module dedisp_checker #(
    parameter int N_CHANNELS = 8,
    parameter int MAX_DELAY  = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  dedisp_regs_pkg::apb_req_t     apb_req,
    input  dedisp_regs_pkg::apb_rsp_t     apb_rsp,
    input  dedisp_stream_pkg::sample_t    sample_in,
    input  logic                          in_valid,
    input  dedisp_stream_pkg::sample_t    sample_out,
    input  logic [$clog2(N_CHANNELS)-1:0] out_chan,
    input  logic                          out_valid,
    input  logic [31:0]                   exp_prdata,
    input  logic                          exp_pslverr,
    input  logic                          done,
    output int                            errors,
    output int                            missing
);
    import dedisp_stream_pkg::*;
    import dedisp_regs_pkg::*;

    localparam int CH_W = $clog2(N_CHANNELS);

    // one output the model expects, tagged with its cycle
    typedef struct packed {
        int              due;
        logic [CH_W-1:0] chan;
        sample_t         data;
    } expect_t;

    // samples held per channel, at most delay of them
    sample_t         hist [N_CHANNELS][$];
    expect_t         pend_q [$];
    int              delay_m [N_CHANNELS];
    logic            en_m;
    logic [CH_W-1:0] chan_m;
    int              cyc;
    logic            done_seen;

    // channel of a delay register address, -1 when unmapped
    function automatic int delay_chan(input logic [11:0] addr);
        int off;
        off = int'(addr) - int'(DELAY_BASE);
        if (off < 0 || off >= N_CHANNELS * DELAY_STRIDE || off % DELAY_STRIDE != 0) begin
            return -1;
        end
        return off / DELAY_STRIDE;
    endfunction

    always @(posedge clk) begin
        expect_t e;
        int      ch;
        if (rst) begin
            en_m      = 1'b0;
            chan_m    = '0;
            cyc       = 0;
            errors    = 0;
            missing   = 0;
            done_seen = 1'b0;
            pend_q.delete();
            for (int c = 0; c < N_CHANNELS; c++) begin
                delay_m[c] = DELAY_RESET;
                hist[c].delete();
            end
        end else begin
            // output due on this edge, or none at all
            if (pend_q.size() != 0 && pend_q[0].due == cyc) begin
                e = pend_q.pop_front();
                if (!out_valid) begin
                    errors++;
                    $display("[ERROR] %0t: no output for channel %0d, expected %h",
                             $time, e.chan, e.data);
                end else if (out_chan != e.chan || sample_out != e.data) begin
                    errors++;
                    $display("[ERROR] %0t: output channel %0d data %h, expected channel %0d data %h",
                             $time, out_chan, sample_out, e.chan, e.data);
                end
            end else if (out_valid) begin
                errors++;
                $display("[ERROR] %0t: unexpected output on channel %0d data %h",
                         $time, out_chan, sample_out);
            end
            // accepted sample, released once more than delay are held
            if (in_valid && en_m) begin
                hist[chan_m].push_back(sample_in);
                if (hist[chan_m].size() > delay_m[chan_m]) begin
                    e.due  = cyc + 3;
                    e.chan = chan_m;
                    e.data = hist[chan_m].pop_front();
                    pend_q.push_back(e);
                end
                chan_m = chan_m + 1'b1;
            end
            // apb response and register mirror
            if (apb_req.psel && apb_req.penable) begin
                // no wait states, every access ends here
                if (!apb_rsp.pready) begin
                    errors++;
                    $display("[ERROR] %0t: pready low at address %h",
                             $time, apb_req.paddr);
                end
                if (apb_rsp.pslverr != exp_pslverr) begin
                    errors++;
                    $display("[ERROR] %0t: pslverr %0b at address %h, expected %0b",
                             $time, apb_rsp.pslverr, apb_req.paddr, exp_pslverr);
                end
                if (!apb_req.pwrite && apb_rsp.prdata != exp_prdata) begin
                    errors++;
                    $display("[ERROR] %0t: read %h at address %h, expected %h",
                             $time, apb_rsp.prdata, apb_req.paddr, exp_prdata);
                end
                ch = delay_chan(apb_req.paddr);
                if (apb_req.pwrite && apb_req.paddr == CTRL_OFFSET) begin
                    en_m = apb_req.pwdata[0];
                end else if (apb_req.pwrite && ch >= 0 && apb_req.pwdata != 0
                             && apb_req.pwdata <= MAX_DELAY) begin
                    // new delay drops the channel history
                    delay_m[ch] = int'(apb_req.pwdata);
                    hist[ch].delete();
                end
            end
            if (done && !done_seen) begin
                done_seen = 1'b1;
                missing   = pend_q.size();
                if (missing != 0) begin
                    $display("%0d expected output samples never appeared", missing);
                end
            end
            cyc++;
        end
    end

endmodule

`default_nettype wire

// File: test/dedisp_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dedisp_top_tb;
    import dedisp_stream_pkg::*;
    import dedisp_regs_pkg::*;

    localparam int N_CHANNELS = 8;
    localparam int MAX_DELAY  = 16;

    logic                          clk;
    logic                          rst;
    apb_req_t                      apb_req;
    apb_rsp_t                      apb_rsp;
    sample_t                       sample_in;
    logic                          in_valid;
    sample_t                       sample_out;
    logic [$clog2(N_CHANNELS)-1:0] out_chan;
    logic                          out_valid;
    // expected apb response for the access in progress
    logic [APB_DATA_W-1:0]         exp_prdata;
    logic                          exp_pslverr;
    logic                          done;
    int                            errors;
    int                            missing;
    integer                        seed;
    int                            limit_ns;
    // enable as last programmed over apb
    logic                          stream_en;

    // one entry per command line of the stimulus file
    logic [7:0]  op_q [$];
    logic [31:0] addr_q [$];
    logic [31:0] data_q [$];
    logic [31:0] err_q [$];

    // 100 ns period
    always #50 clk = ~clk;

    dedisp_top #(
        .N_CHANNELS (N_CHANNELS),
        .MAX_DELAY  (MAX_DELAY)
    ) UUT (.*);

    dedisp_checker #(
        .N_CHANNELS (N_CHANNELS),
        .MAX_DELAY  (MAX_DELAY)
    ) u_checker (.*);

    // parse the command file, return a cycle estimate for the watchdog
    // -1 when the file cannot be opened
    task automatic read_stimulus(output int cycles);
        int              fd;
        int              n;
        logic [8*64-1:0] line;
        logic [7:0]      tok;
        logic [31:0]     a0;
        logic [31:0]     a1;
        logic [31:0]     a2;
        cycles = 0;
        fd = $fopen("test/dedisp_input.txt", "r");
        if (fd == 0) begin
            cycles = -1;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%s %h %h %h", tok, a0, a1, a2);
                    // comment lines start with a lone hash
                    if (n >= 2 && tok != "#") begin
                        op_q.push_back(tok);
                        addr_q.push_back(a0);
                        data_q.push_back(a1);
                        err_q.push_back(a2);
                        // worst case is three idle cycles before each sample
                        cycles = cycles + ((tok == "S") ? int'(a0) * N_CHANNELS * 4 : 3);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // setup, access, then one idle cycle
    task automatic apb_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] data, input logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr[APB_ADDR_W-1:0];
        apb_req.pwdata  = write ? data : '0;
        exp_prdata      = write ? '0 : data;
        exp_pslverr     = err;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        // delay_load reaches the delay lines during this cycle
        @(negedge clk);
    endtask

    // whole spectra with random gaps, junk data while in_valid is low
    task automatic send_frames(input int frames);
        int gap;
        int count;
        // one extra sample while disabled, off the frame grid
        // a channel counter that moved would then shift every later channel
        count = frames * N_CHANNELS + (stream_en ? 0 : 1);
        for (int i = 0; i < count; i++) begin
            gap = $random(seed) & 3;
            repeat (gap) begin
                in_valid  = 1'b0;
                sample_in = $random(seed);
                @(negedge clk);
            end
            in_valid  = 1'b1;
            sample_in = $random(seed);
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    initial begin
        int cycles;
        clk         = 1'b0;
        rst         = 1'b1;
        apb_req     = '0;
        sample_in   = '0;
        in_valid    = 1'b0;
        exp_prdata  = '0;
        exp_pslverr = 1'b0;
        done        = 1'b0;
        seed        = 32'he82f;
        limit_ns    = 0;
        stream_en   = 1'b0;
        read_stimulus(cycles);
        if (cycles < 0) begin
            $display("cannot open the stimulus file test/dedisp_input.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            limit_ns = 20 * (cycles + 10) * 100;
            repeat (5) @(negedge clk);
            rst = 1'b0;
            for (int i = 0; i < op_q.size(); i++) begin
                case (op_q[i])
                    "W": begin
                        apb_access(1'b1, addr_q[i], data_q[i], err_q[i][0]);
                        if (addr_q[i][APB_ADDR_W-1:0] == CTRL_OFFSET && !err_q[i][0]) begin
                            stream_en = data_q[i][0];
                        end
                    end
                    "R":     apb_access(1'b0, addr_q[i], data_q[i], 1'b0);
                    default: send_frames(int'(addr_q[i]));
                endcase
            end
            // last accepted sample shows up three edges later
            repeat (4) @(negedge clk);
            done = 1'b1;
            repeat (2) @(negedge clk);
            $display("error counts: %0d wrong values, %0d missing outputs", errors, missing);
            if (errors == 0 && missing == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

    // watchdog, armed once the file length is known
    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("timeout: simulation still running after %0d ns", limit_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/dedisp_input.txt
# W addr data pslverr | R addr expected_data | S frame_count
# every number is hex
R 000 0
R 01c 1
W 010 3 0
W 014 0 1
W 018 11 1
W 004 5 1
W 012 2 1
W 018 10 0
W 01c 6 0
R 014 1
R 018 10
S 3
W 000 1 0
R 000 1
S 14
W 01c 9 0
R 01c 9
S 14
W 000 0 0
S 2
W 000 1 0
S 6

// File: dedisp_top.f
design/dedisp_stream_pkg.sv
design/dedisp_regs_pkg.sv
design/dedisp_delay_line.sv
design/dedispersor.sv
design/dedisp_apb_regs.sv
design/dedisp_top.sv
test/dedisp_checker.sv
test/dedisp_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dedispersion testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f dedisp_top.f --top-module dedisp_top_tb -o sim_dedisp

# result is taken from the simulation output only
out=$(./obj_dir/sim_dedisp || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qxF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
